// File: hdl/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

	typedef logic signed [31:0] arg_t;

	localparam int CMD_BITS = 5;
	typedef logic [CMD_BITS-1:0] cmd_t;

	localparam int MAX_ARGS = 8;
	localparam int ARGS_BITS = 3;
	typedef logic [ARGS_BITS-1:0] nargs_t;

	// Unit ids double as bit positions in the per-unit handshake vectors
	typedef enum logic [1:0] {
		UNIT_SYSTEM = 2'd0,
		UNIT_GPIO = 2'd1,
		UNIT_NONE = 2'd3
	} unit_t;
	localparam int NUNITS = 2;

	localparam cmd_t CMD_GET_VERSION = 5'd0;
	localparam cmd_t CMD_GET_TIME = 5'd2;
	localparam cmd_t CMD_SET_DIGITAL_OUT = 5'd15;

	localparam logic [7:0] RSP_GET_VERSION = 8'd0;
	localparam logic [7:0] RSP_GET_TIME = 8'd1;

	typedef struct packed {
		unit_t unit;
		nargs_t nargs;
		logic has_response;
	} cmd_entry_t;

	localparam cmd_entry_t CMD_TABLE [2**CMD_BITS] = '{
		CMD_GET_VERSION: '{unit: UNIT_SYSTEM, nargs: 3'd0, has_response: 1'b1},
		CMD_GET_TIME: '{unit: UNIT_SYSTEM, nargs: 3'd0, has_response: 1'b1},
		CMD_SET_DIGITAL_OUT: '{unit: UNIT_GPIO, nargs: 3'd2, has_response: 1'b0},
		default: '{unit: UNIT_NONE, nargs: 3'd0, has_response: 1'b0}
	};

	localparam int MAX_PARAMS = 4;
	localparam int PARAM_BITS = 2;

	localparam int LEN_BITS = 8;

endpackage

`default_nettype wire

// File: hdl/vlq_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module vlq_decoder (
	input wire clk,
	input wire rst_n,
	input wire [7:0] msg_data,
	input wire msg_ready,
	input wire busy,
	output logic msg_rd_en,
	output cmd_pkg::arg_t arg_data,
	output logic [cmd_pkg::ARGS_BITS-1:0] arg_index,
	output logic arg_write,
	output logic cmd_valid,
	output cmd_pkg::cmd_t cmd,
	output cmd_pkg::unit_t unit,
	output logic has_response
);
	import cmd_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_ARG_START, ST_ARG_CONT, ST_ARG_END} state_t;

	state_t state;
	nargs_t nargs;
	nargs_t arg_cnt;
	cmd_entry_t entry;
	logic take;
	logic arg_last;

	// Ids beyond the table width have no entry
	always_comb begin
		if (msg_data[7:CMD_BITS] == '0)
			entry = CMD_TABLE[msg_data[CMD_BITS-1:0]];
		else
			entry = '{unit: UNIT_NONE, nargs: '0, has_response: 1'b0};
	end

	// The byte on msg_data is decoded now and popped by the strobe in the next cycle
	assign take = msg_ready && !msg_rd_en && !busy && !cmd_valid && state != ST_ARG_END;
	assign arg_last = (state == ST_ARG_START || state == ST_ARG_CONT) && !msg_data[7];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			msg_rd_en <= 1'b0;
			arg_write <= 1'b0;
			cmd_valid <= 1'b0;
			nargs <= '0;
			arg_cnt <= '0;
		end else begin
			msg_rd_en <= take;
			arg_write <= take && arg_last;
			cmd_valid <= 1'b0;
			case (state)
			ST_IDLE: if (take) begin
				nargs <= entry.nargs;
				arg_cnt <= '0;
				if (entry.unit == UNIT_NONE)
					state <= ST_IDLE;  // Unknown id, only the id byte is dropped
				else if (entry.nargs == '0)
					state <= ST_ARG_END;
				else
					state <= ST_ARG_START;
			end
			ST_ARG_START: if (take)
				state <= msg_data[7] ? ST_ARG_CONT : ST_ARG_END;
			ST_ARG_CONT: if (take && !msg_data[7])
				state <= ST_ARG_END;
			ST_ARG_END: begin
				if (arg_cnt == nargs) begin
					cmd_valid <= 1'b1;
					state <= ST_IDLE;
				end else
					state <= ST_ARG_START;
			end
			default: state <= ST_IDLE;
			endcase
			if (take && arg_last)
				arg_cnt <= arg_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			case (state)
			ST_IDLE: begin
				cmd <= msg_data[CMD_BITS-1:0];
				unit <= entry.unit;
				has_response <= entry.has_response;
			end
			// A first byte with bits 6:5 set starts a negative value
			ST_ARG_START: arg_data <= {{25{msg_data[6] & msg_data[5]}}, msg_data[6:0]};
			default: arg_data <= {arg_data[24:0], msg_data[6:0]};
			endcase
			if (arg_last)
				arg_index <= arg_cnt;
		end
	end

	// No byte may be popped while the dispatcher still owns the previous command
	assert property (@(posedge clk) disable iff (!rst_n) msg_rd_en |-> !busy)
		else $error("msg_rd_en raised while dispatcher busy");

endmodule

`default_nettype wire

// File: hdl/cmd_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch (
	input wire clk,
	input wire rst_n,
	input wire cmd_pkg::arg_t arg_data,
	input wire [cmd_pkg::ARGS_BITS-1:0] arg_index,
	input wire arg_write,
	input wire cmd_valid,
	input wire cmd_pkg::cmd_t cmd,
	input wire cmd_pkg::unit_t unit,
	input wire has_response,
	input wire [cmd_pkg::NUNITS-1:0] unit_arg_advance,
	input wire [cmd_pkg::NUNITS-1:0] unit_cmd_done,
	input wire [cmd_pkg::NUNITS-1:0] unit_param_write,
	input wire cmd_pkg::arg_t sys_param_data,
	input wire cmd_pkg::arg_t gpio_param_data,
	input wire [cmd_pkg::PARAM_BITS-1:0] param_index,
	input wire rsp_sent,
	output logic busy,
	output cmd_pkg::cmd_t unit_cmd,
	output logic [cmd_pkg::NUNITS-1:0] unit_cmd_ready,
	output cmd_pkg::arg_t unit_arg_data,
	output logic rsp_start,
	output logic [7:0] rsp_id,
	output logic [cmd_pkg::PARAM_BITS:0] nparams,
	output cmd_pkg::arg_t param_word
);
	import cmd_pkg::*;

	typedef enum logic [1:0] {DS_IDLE, DS_RUN, DS_SEND} state_t;

	state_t state;
	unit_t sel_unit;
	logic sel_rsp;
	logic [NUNITS-1:0] sel_mask;
	logic [ARGS_BITS-1:0] arg_ptr;
	arg_t args [MAX_ARGS];
	arg_t params [MAX_PARAMS];
	arg_t sel_param;
	logic sel_advance;
	logic sel_write;
	logic sel_done;

	assign busy = (state != DS_IDLE);

	// Handshakes from units that do not own the command are ignored
	assign sel_mask = NUNITS'(1) << sel_unit;
	assign sel_advance = |(unit_arg_advance & sel_mask);
	assign sel_write = |(unit_param_write & sel_mask);
	assign sel_done = |(unit_cmd_done & sel_mask);
	assign sel_param = (sel_unit == UNIT_GPIO) ? gpio_param_data : sys_param_data;

	assign param_word = params[param_index];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= DS_IDLE;
			sel_unit <= UNIT_NONE;
			sel_rsp <= 1'b0;
			unit_cmd_ready <= '0;
			rsp_start <= 1'b0;
			nparams <= '0;
			arg_ptr <= '0;
		end else begin
			unit_cmd_ready <= '0;
			rsp_start <= 1'b0;
			case (state)
			DS_IDLE: if (cmd_valid) begin
				sel_unit <= unit;
				sel_rsp <= has_response;
				unit_cmd_ready <= NUNITS'(1) << unit;
				nparams <= '0;
				arg_ptr <= ARGS_BITS'(1);  // Argument 0 goes out together with cmd_ready
				state <= DS_RUN;
			end
			DS_RUN: begin
				if (sel_advance)
					arg_ptr <= arg_ptr + 1'b1;
				if (sel_write)
					nparams <= nparams + 1'b1;
				if (sel_done) begin
					rsp_start <= sel_rsp;
					state <= sel_rsp ? DS_SEND : DS_IDLE;
				end
			end
			DS_SEND: if (rsp_sent)
				state <= DS_IDLE;
			default: state <= DS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (arg_write)
			args[arg_index] <= arg_data;
		if (state == DS_IDLE && cmd_valid) begin
			unit_cmd <= cmd;
			unit_arg_data <= args[0];
		end else if (state == DS_RUN && sel_advance)
			unit_arg_data <= args[arg_ptr];
		if (state == DS_RUN && sel_write)
			params[nparams[PARAM_BITS-1:0]] <= sel_param;
		if (state == DS_RUN && sel_done)
			rsp_id <= sel_param[7:0];  // The done cycle carries the response id
	end

	// Only the unit that was handed the command may finish it
	assert property (@(posedge clk) disable iff (!rst_n)
		(|unit_cmd_done) |-> (state == DS_RUN && (unit_cmd_done & ~sel_mask) == '0))
		else $error("cmd_done from a unit that does not own the command");

	assert property (@(posedge clk) disable iff (!rst_n) nparams <= MAX_PARAMS)
		else $error("unit wrote more than MAX_PARAMS parameters");

endmodule

`default_nettype wire

// File: hdl/vlq_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module vlq_encoder (
	input wire clk,
	input wire rst_n,
	input wire rsp_start,
	input wire [7:0] rsp_id,
	input wire [cmd_pkg::PARAM_BITS:0] nparams,
	input wire cmd_pkg::arg_t param_word,
	input wire send_ring_full,
	input wire send_fifo_full,
	output logic [cmd_pkg::PARAM_BITS-1:0] param_index,
	output logic rsp_sent,
	output logic [7:0] send_ring_data,
	output logic send_ring_wr_en,
	output logic [cmd_pkg::LEN_BITS-1:0] send_fifo_data,
	output logic send_fifo_wr_en
);
	import cmd_pkg::*;

	typedef enum logic [1:0] {EN_IDLE, EN_ID, EN_LOAD, EN_SEND} state_t;

	state_t state;
	logic [7:0] id_q;
	logic [PARAM_BITS:0] np_q;
	logic [LEN_BITS-1:0] len;
	logic [2:0] cnt;
	logic [34:0] sh;
	logic [34:0] ext;
	logic [2:0] nbytes;
	logic last_param;
	logic last_byte;

	assign ext = {{3{param_word[31]}}, param_word};  // Five 7-bit groups

	// Leading groups that only repeat the sign are not sent
	always_comb begin
		if (param_word >= -32'sh20 && param_word <= 32'sh5F)
			nbytes = 3'd1;
		else if (param_word >= -32'sh1000 && param_word <= 32'sh2FFF)
			nbytes = 3'd2;
		else if (param_word >= -32'sh80000 && param_word <= 32'sh17FFFF)
			nbytes = 3'd3;
		else if (param_word >= -32'sh4000000 && param_word <= 32'shBFFFFFF)
			nbytes = 3'd4;
		else
			nbytes = 3'd5;
	end

	assign last_param = ((PARAM_BITS+1)'(param_index) + 1'b1) == np_q;
	assign last_byte = (state == EN_ID && np_q == '0) ||
		(state == EN_SEND && cnt == 3'd1 && last_param);

	always_comb begin
		send_ring_wr_en = 1'b0;
		send_ring_data = id_q;
		if (state == EN_ID)
			send_ring_wr_en = !send_ring_full && !send_fifo_full;  // Length slot must be free
		else if (state == EN_SEND) begin
			send_ring_wr_en = !send_ring_full;
			send_ring_data = {cnt != 3'd1, sh[34:28]};
		end
	end

	assign send_fifo_wr_en = send_ring_wr_en && last_byte;
	assign send_fifo_data = len + 1'b1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= EN_IDLE;
			rsp_sent <= 1'b0;
			param_index <= '0;
			np_q <= '0;
			len <= '0;
			cnt <= '0;
		end else begin
			rsp_sent <= 1'b0;
			if (send_ring_wr_en)
				len <= len + 1'b1;
			case (state)
			EN_IDLE: if (rsp_start) begin
				np_q <= nparams;
				param_index <= '0;
				len <= '0;
				state <= EN_ID;
			end
			EN_ID: if (send_ring_wr_en)
				state <= last_byte ? EN_IDLE : EN_LOAD;
			EN_LOAD: begin
				cnt <= nbytes;
				state <= EN_SEND;
			end
			EN_SEND: if (send_ring_wr_en) begin
				cnt <= cnt - 1'b1;
				if (cnt == 3'd1) begin
					if (last_param)
						state <= EN_IDLE;
					else begin
						param_index <= param_index + 1'b1;
						state <= EN_LOAD;
					end
				end
			end
			default: state <= EN_IDLE;
			endcase
			if (send_fifo_wr_en)
				rsp_sent <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == EN_IDLE && rsp_start)
			id_q <= rsp_id;
		if (state == EN_LOAD)
			sh <= ext << (7 * (5 - nbytes));
		else if (state == EN_SEND && send_ring_wr_en)
			sh <= sh << 7;
	end

	assert property (@(posedge clk) disable iff (!rst_n) send_ring_wr_en |-> !send_ring_full)
		else $error("ring write while send_ring_full");

endmodule

`default_nettype wire

// File: hdl/unit_system.sv
`timescale 1ns/1ps
`default_nettype none

module unit_system #(
	parameter logic [31:0] VERSION = 32'h00010203
) (
	input wire clk,
	input wire rst_n,
	input wire cmd_pkg::cmd_t cmd,
	input wire cmd_ready,
	input wire cmd_pkg::arg_t systime,
	output logic arg_advance,
	output cmd_pkg::arg_t param_data,
	output logic param_write,
	output logic cmd_done
);
	import cmd_pkg::*;

	logic [7:0] rsp_q;
	logic known;

	assign known = (cmd == CMD_GET_VERSION) || (cmd == CMD_GET_TIME);
	assign arg_advance = 1'b0;  // Neither command takes arguments

	// The single parameter is written in the cmd_ready cycle, so get_time
	// reports the time at which the command reached the unit
	assign param_write = cmd_ready && known;

	always_comb begin
		if (cmd_done)
			param_data = {24'd0, rsp_q};
		else if (cmd == CMD_GET_TIME)
			param_data = systime;
		else
			param_data = VERSION;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cmd_done <= 1'b0;
		else
			cmd_done <= cmd_ready;
	end

	always_ff @(posedge clk) begin
		if (cmd_ready)
			rsp_q <= (cmd == CMD_GET_TIME) ? RSP_GET_TIME : RSP_GET_VERSION;
	end

endmodule

`default_nettype wire

// File: hdl/unit_gpio.sv
`timescale 1ns/1ps
`default_nettype none

module unit_gpio #(
	parameter int NGPIO = 8
) (
	input wire clk,
	input wire rst_n,
	input wire cmd_pkg::cmd_t cmd,
	input wire cmd_ready,
	input wire cmd_pkg::arg_t arg_data,
	output logic arg_advance,
	output cmd_pkg::arg_t param_data,
	output logic param_write,
	output logic cmd_done,
	output logic [NGPIO-1:0] gpio
);
	import cmd_pkg::*;

	logic is_set;
	logic pending;
	arg_t channel;

	assign is_set = (cmd == CMD_SET_DIGITAL_OUT);
	assign arg_advance = cmd_ready && is_set;  // Channel now, value one cycle later

	// set_digital_out has no response
	assign param_data = '0;
	assign param_write = 1'b0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
			cmd_done <= 1'b0;
			gpio <= '0;
		end else begin
			pending <= cmd_ready;
			cmd_done <= pending;
			if (pending && is_set) begin
				// Channels outside the gpio range match no bit
				for (int i = 0; i < NGPIO; i++)
					if (channel == i)
						gpio[i] <= arg_data[0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_ready)
			channel <= arg_data;
	end

endmodule

`default_nettype wire

// File: hdl/command_top.sv
`timescale 1ns/1ps
`default_nettype none

module command_top #(
	parameter logic [31:0] VERSION = 32'h00010203,
	parameter int NGPIO = 8
) (
	input wire clk,
	input wire rst_n,
	input wire [7:0] msg_data,
	input wire msg_ready,
	input wire cmd_pkg::arg_t systime,
	input wire send_ring_full,
	input wire send_fifo_full,
	output wire msg_rd_en,
	output wire [7:0] send_ring_data,
	output wire send_ring_wr_en,
	output wire [cmd_pkg::LEN_BITS-1:0] send_fifo_data,
	output wire send_fifo_wr_en,
	output wire [NGPIO-1:0] gpio
);
	import cmd_pkg::*;

	arg_t arg_data;
	logic [ARGS_BITS-1:0] arg_index;
	logic arg_write;
	logic cmd_valid;
	cmd_t cmd;
	unit_t unit;
	logic has_response;
	logic busy;

	cmd_t unit_cmd;
	arg_t unit_arg_data;
	logic [NUNITS-1:0] unit_cmd_ready;
	logic [NUNITS-1:0] unit_arg_advance;
	logic [NUNITS-1:0] unit_cmd_done;
	logic [NUNITS-1:0] unit_param_write;
	arg_t sys_param_data;
	arg_t gpio_param_data;
	logic sys_cmd_ready, sys_arg_advance, sys_cmd_done, sys_param_write;
	logic gpio_cmd_ready, gpio_arg_advance, gpio_cmd_done, gpio_param_write;

	logic rsp_start;
	logic [7:0] rsp_id;
	logic [PARAM_BITS:0] nparams;
	logic [PARAM_BITS-1:0] param_index;
	arg_t param_word;
	logic rsp_sent;

	// Bit order follows the unit ids, system in bit 0
	assign {gpio_cmd_ready, sys_cmd_ready} = unit_cmd_ready;
	assign unit_arg_advance = {gpio_arg_advance, sys_arg_advance};
	assign unit_cmd_done = {gpio_cmd_done, sys_cmd_done};
	assign unit_param_write = {gpio_param_write, sys_param_write};

	vlq_decoder u_decoder (
		.clk(clk), .rst_n(rst_n), .msg_data(msg_data), .msg_ready(msg_ready), .busy(busy),
		.msg_rd_en(msg_rd_en), .arg_data(arg_data), .arg_index(arg_index),
		.arg_write(arg_write), .cmd_valid(cmd_valid), .cmd(cmd), .unit(unit),
		.has_response(has_response)
	);

	cmd_dispatch u_dispatch (
		.clk(clk), .rst_n(rst_n), .arg_data(arg_data), .arg_index(arg_index),
		.arg_write(arg_write), .cmd_valid(cmd_valid), .cmd(cmd), .unit(unit),
		.has_response(has_response), .unit_arg_advance(unit_arg_advance),
		.unit_cmd_done(unit_cmd_done), .unit_param_write(unit_param_write),
		.sys_param_data(sys_param_data), .gpio_param_data(gpio_param_data),
		.param_index(param_index), .rsp_sent(rsp_sent), .busy(busy), .unit_cmd(unit_cmd),
		.unit_cmd_ready(unit_cmd_ready), .unit_arg_data(unit_arg_data),
		.rsp_start(rsp_start), .rsp_id(rsp_id), .nparams(nparams), .param_word(param_word)
	);

	unit_system #(.VERSION(VERSION)) u_system (
		.clk(clk), .rst_n(rst_n), .cmd(unit_cmd), .cmd_ready(sys_cmd_ready),
		.systime(systime), .arg_advance(sys_arg_advance), .param_data(sys_param_data),
		.param_write(sys_param_write), .cmd_done(sys_cmd_done)
	);

	unit_gpio #(.NGPIO(NGPIO)) u_gpio (
		.clk(clk), .rst_n(rst_n), .cmd(unit_cmd), .cmd_ready(gpio_cmd_ready),
		.arg_data(unit_arg_data), .arg_advance(gpio_arg_advance),
		.param_data(gpio_param_data), .param_write(gpio_param_write),
		.cmd_done(gpio_cmd_done), .gpio(gpio)
	);

	vlq_encoder u_encoder (
		.clk(clk), .rst_n(rst_n), .rsp_start(rsp_start), .rsp_id(rsp_id),
		.nparams(nparams), .param_word(param_word), .send_ring_full(send_ring_full),
		.send_fifo_full(send_fifo_full), .param_index(param_index), .rsp_sent(rsp_sent),
		.send_ring_data(send_ring_data), .send_ring_wr_en(send_ring_wr_en),
		.send_fifo_data(send_fifo_data), .send_fifo_wr_en(send_fifo_wr_en)
	);

endmodule

`default_nettype wire

// File: tb/cmd_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_checker #(
	parameter int NGPIO = 8
) (
	input wire clk,
	input wire rst_n,
	input wire msg_rd_en,
	input wire [7:0] send_ring_data,
	input wire send_ring_wr_en,
	input wire send_ring_full,
	input wire [cmd_pkg::LEN_BITS-1:0] send_fifo_data,
	input wire send_fifo_wr_en,
	input wire [NGPIO-1:0] gpio
);
	import cmd_pkg::*;

	logic [7:0] exp_bytes[$];  // The list only grows and byte_ptr walks through it
	logic [LEN_BITS-1:0] exp_lens[$];
	int byte_ptr = 0;
	int lens_seen = 0;
	int mon_errors = 0;
	int task_errors = 0;
	int errors_before = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic rd_en_q = 1'b0;

	function void expect_byte(input logic [7:0] b);
		exp_bytes.push_back(b);
	endfunction

	function void expect_len(input logic [LEN_BITS-1:0] len);
		exp_lens.push_back(len);
	endfunction

	function int total_errors();
		return mon_errors + task_errors;
	endfunction

	// Writes are sampled on the edge where the ring and the length FIFO take them
	always @(posedge clk) begin
		if (rst_n && send_ring_wr_en) begin
			if (send_ring_full) begin
				$display("Ring byte 0x%02h written while send_ring_full was high", send_ring_data);
				mon_errors++;
			end
			if (byte_ptr >= exp_bytes.size()) begin
				$display("Unexpected ring byte 0x%02h with no response pending", send_ring_data);
				mon_errors++;
			end else if (send_ring_data !== exp_bytes[byte_ptr]) begin
				$display("Error send_ring_data got 0x%02h expected 0x%02h",
					send_ring_data, exp_bytes[byte_ptr]);
				mon_errors++;
			end
			byte_ptr++;
		end
		if (rst_n && send_fifo_wr_en) begin
			// The length word goes with the last byte of its response
			if (byte_ptr != exp_bytes.size()) begin
				$display("Length word written before the last byte of its response");
				mon_errors++;
			end
			if (lens_seen >= exp_lens.size()) begin
				$display("Unexpected length word 0x%02h with no response pending", send_fifo_data);
				mon_errors++;
			end else if (send_fifo_data !== exp_lens[lens_seen]) begin
				$display("Error send_fifo_data got 0x%02h expected 0x%02h",
					send_fifo_data, exp_lens[lens_seen]);
				mon_errors++;
			end
			lens_seen++;
		end
		// The byte FIFO strobe is a single-cycle pulse
		if (rst_n && msg_rd_en && rd_en_q) begin
			$display("msg_rd_en stayed high for two consecutive cycles");
			mon_errors++;
		end
		rd_en_q <= msg_rd_en;
	end

	task automatic check_gpio(input logic [NGPIO-1:0] expected);
		if (gpio !== expected) begin
			$display("Error gpio got 0x%02h expected 0x%02h", gpio, expected);
			task_errors++;
		end
	endtask

	task automatic finish_test(input string name, input logic [NGPIO-1:0] gpio_expected);
		int errs;
		check_gpio(gpio_expected);
		if (byte_ptr < exp_bytes.size()) begin
			$display("Response incomplete, %0d ring bytes never arrived",
				exp_bytes.size() - byte_ptr);
			task_errors++;
		end
		if (lens_seen < exp_lens.size()) begin
			$display("%0d length words never arrived", exp_lens.size() - lens_seen);
			task_errors++;
		end
		errs = total_errors() - errors_before;
		errors_before = total_errors();
		tests_run++;
		if (errs == 0)
			$display("Test %0d %s: ok", tests_run, name);
		else begin
			tests_failed++;
			$display("Test %0d %s: %0d errors", tests_run, name, errs);
		end
	endtask

	function void report();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			total_errors());
	endfunction

endmodule

`default_nettype wire

// File: tb/tb_command.sv
`timescale 1ns/1ps
`default_nettype none

module tb_command;
	import cmd_pkg::*;

	localparam logic [31:0] VERSION = 32'h00010203;
	localparam int NGPIO = 8;
	localparam int NTESTS = 6;
	localparam int CYCLES_PER_TEST = 2000;
	// Cycles from the last consumed byte through cmd_valid and cmd_ready to cmd_done
	localparam int GPIO_LATENCY = 4;
	localparam arg_t EDGES [9] = '{32'sh5F, 32'sh60, -32'sh20, -32'sh21, 32'sh2FFF,
		32'sh3000, 32'shBFFFFFF, 32'shC000000, 32'sh80000000};

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic [7:0] msg_data = 8'h00;
	logic msg_ready = 1'b0;
	arg_t systime = '0;
	logic send_ring_full = 1'b0;
	logic send_fifo_full = 1'b0;
	wire msg_rd_en;
	wire [7:0] send_ring_data;
	wire send_ring_wr_en;
	wire [LEN_BITS-1:0] send_fifo_data;
	wire send_fifo_wr_en;
	wire [NGPIO-1:0] gpio;

	integer seed = 384;
	logic [7:0] byte_q[$];  // Every byte the host has queued with src_ptr at the head
	int src_ptr = 0;
	logic [7:0] enc_q[$];
	logic [NGPIO-1:0] gpio_exp = '0;
	logic ring_stress = 1'b0;
	logic [255:0] full_bits = '0;
	logic [7:0] full_idx = '0;
	logic [31:0] rnd;
	arg_t val;
	int ch;
	int target;

	command_top #(.VERSION(VERSION), .NGPIO(NGPIO)) dut0 (
		.clk(clk), .rst_n(rst_n), .msg_data(msg_data), .msg_ready(msg_ready),
		.systime(systime), .send_ring_full(send_ring_full), .send_fifo_full(send_fifo_full),
		.msg_rd_en(msg_rd_en), .send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en), .send_fifo_data(send_fifo_data),
		.send_fifo_wr_en(send_fifo_wr_en), .gpio(gpio)
	);

	cmd_checker #(.NGPIO(NGPIO)) chk0 (
		.clk(clk), .rst_n(rst_n), .msg_rd_en(msg_rd_en), .send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en), .send_ring_full(send_ring_full),
		.send_fifo_data(send_fifo_data), .send_fifo_wr_en(send_fifo_wr_en), .gpio(gpio)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	// The byte FIFO moves its head on once the decoder has strobed it
	always @(posedge clk) begin
		if (msg_rd_en && msg_ready)
			src_ptr = src_ptr + 1;
		msg_ready <= (src_ptr < byte_q.size());
		msg_data <= (src_ptr < byte_q.size()) ? byte_q[src_ptr] : 8'h00;
	end

	always @(posedge clk) begin
		send_ring_full <= ring_stress && full_bits[full_idx];
		full_idx <= full_idx + 1'b1;
	end

	// Emits the minimal VLQ form of v with the most significant group first
	function automatic void append_vlq(input longint v);
		int n;
		longint lim;
		n = 5;
		for (int k = 4; k >= 1; k--) begin
			lim = longint'(1) <<< (7 * k - 2);
			if (v >= -lim && v < 3 * lim)
				n = k;
		end
		for (int i = n - 1; i >= 0; i--)
			enc_q.push_back({i != 0, 7'(v >>> (7 * i))});
	endfunction

	function automatic void ref_response(input logic [7:0] rsp, input arg_t value);
		enc_q.delete();
		enc_q.push_back(rsp);
		append_vlq(longint'(value));
		foreach (enc_q[i])
			chk0.expect_byte(enc_q[i]);
		chk0.expect_len(LEN_BITS'(enc_q.size()));
	endfunction

	task automatic send_enc();
		@(negedge clk);
		foreach (enc_q[i])
			byte_q.push_back(enc_q[i]);
	endtask

	task automatic wait_lengths(input int goal);
		while (chk0.lens_seen < goal)
			@(negedge clk);
	endtask

	task automatic run_response(input cmd_t id, input logic [7:0] rsp, input arg_t value);
		int goal;
		goal = chk0.lens_seen + 1;
		ref_response(rsp, value);
		enc_q.delete();
		enc_q.push_back(8'(id));
		send_enc();
		wait_lengths(goal);
	endtask

	task automatic run_time(input arg_t t);
		@(posedge clk);
		systime <= t;  // Stays put until the next get_time
		run_response(CMD_GET_TIME, RSP_GET_TIME, t);
	endtask

	initial begin
		repeat (NTESTS * CYCLES_PER_TEST) @(posedge clk);
		$display("Timeout: the DUT stalled, tests unfinished after %0d cycles",
			NTESTS * CYCLES_PER_TEST);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);

		run_response(CMD_GET_VERSION, RSP_GET_VERSION, VERSION);
		chk0.finish_test("get_version", gpio_exp);

		rnd = $random(seed);
		run_time(rnd);
		chk0.finish_test("get_time", gpio_exp);

		for (int i = 0; i < 9; i++)
			run_time(EDGES[i]);
		chk0.finish_test("encoding lengths", gpio_exp);

		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			ch = int'(rnd[7:0]) % NGPIO;
			val = $random(seed);
			if (i >= 4)
				val = val >>> 20;  // Shorter values that are often negative
			enc_q.delete();
			enc_q.push_back(8'(CMD_SET_DIGITAL_OUT));
			if (i % 2 == 1)
				enc_q.push_back(8'h80);  // Redundant zero group makes a two-byte channel
			append_vlq(longint'(ch));
			append_vlq(longint'(val));
			gpio_exp[ch] = val[0];
			send_enc();
			while (src_ptr < byte_q.size())
				@(negedge clk);
			repeat (GPIO_LATENCY) @(posedge clk);
			@(negedge clk);
			chk0.check_gpio(gpio_exp);
		end
		chk0.finish_test("set_digital_out", gpio_exp);

		for (int k = 0; k < 8; k++)
			full_bits[k*32 +: 32] = $random(seed);
		@(negedge clk);
		ring_stress = 1'b1;
		for (int i = 0; i < 3; i++) begin
			run_response(CMD_GET_VERSION, RSP_GET_VERSION, VERSION);
			rnd = $random(seed);
			run_time(rnd);
		end
		@(negedge clk);
		ring_stress = 1'b0;
		chk0.finish_test("ring back-pressure", gpio_exp);

		// Id 7 has no entry and 0x28 lies beyond the table
		target = chk0.lens_seen + 1;
		ref_response(RSP_GET_VERSION, VERSION);
		enc_q = '{8'd7, 8'h28, 8'h00};
		send_enc();
		wait_lengths(target);
		chk0.finish_test("unknown id", gpio_exp);

		chk0.report();
		if (chk0.total_errors() == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
hdl/cmd_pkg.sv
hdl/vlq_decoder.sv
hdl/cmd_dispatch.sv
hdl/vlq_encoder.sv
hdl/unit_system.sv
hdl/unit_gpio.sv
hdl/command_top.sv
tb/cmd_checker.sv
tb/tb_command.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f vlog.f --top-module tb_command -o tb_command_sim \
	&& ./obj_dir/tb_command_sim > sim.log 2>&1 \
	|| echo "FAIL: see errors above" >> sim.log
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
